// File: fv_bank_pkg.sv
package fv_bank_pkg;

    // line geometry
    localparam int FV_LINE_WIDTH  = 64;
    localparam int FVS_PER_LINE   = 2;
    // widest node, in feature values
    localparam int MAX_FV_NUM     = 16;
    localparam int LINES_PER_NODE = MAX_FV_NUM / FVS_PER_LINE;
    localparam int LINE_IDX_WIDTH = $clog2(LINES_PER_NODE);
    // count widths hold the full value, not just max-1
    localparam int LINE_CNT_WIDTH = $clog2(LINES_PER_NODE + 1);
    localparam int FV_CNT_WIDTH   = $clog2(MAX_FV_NUM + 1);

    // node id space
    localparam int NODE_ID_WIDTH  = 6;
    localparam int BANK_ADDR_WIDTH = NODE_ID_WIDTH + LINE_IDX_WIDTH;

    // edge pe fan-out
    localparam int NUM_EDGE_PE    = 4;
    localparam int PE_TAG_WIDTH   = $clog2(NUM_EDGE_PE);

    typedef logic [FV_LINE_WIDTH-1:0]   fv_line_t;
    typedef logic [NODE_ID_WIDTH-1:0]   node_id_t;
    typedef logic [LINE_IDX_WIDTH-1:0]  line_idx_t;
    typedef logic [LINE_CNT_WIDTH-1:0]  line_cnt_t;
    typedef logic [FV_CNT_WIDTH-1:0]    fv_count_t;
    typedef logic [PE_TAG_WIDTH-1:0]    pe_tag_t;
    // node id in the upper bits, line index below
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // request beat from write-back buffer or edge pe
    typedef struct packed {
        logic      valid;
        // high for write-back, low for edge pe read
        logic      rd_wr;
        // last beat of a write burst
        logic      wr_eos;
        node_id_t  node_id;
        pe_tag_t   pe_tag;
        fv_count_t fv_num;
        fv_line_t  data;
    } bank_req_t;

    // decoded beat kinds
    typedef enum logic [1:0] {
        OP_NONE       = 2'd0,
        OP_READ_START = 2'd1,
        OP_WRITE_BEAT = 2'd2
    } op_kind_t;

    // registered request, read length already in lines
    typedef struct packed {
        op_kind_t  kind;
        logic      wr_eos;
        node_id_t  node_id;
        pe_tag_t   pe_tag;
        line_cnt_t line_cnt;
        fv_line_t  data;
    } bank_op_t;

    // one bank access, wr low means read
    typedef struct packed {
        logic       en;
        logic       wr;
        bank_addr_t addr;
        fv_line_t   data;
    } bank_cmd_t;

    // stream markers riding along with a read command
    typedef struct packed {
        logic    valid;
        logic    sos;
        logic    eos;
        pe_tag_t pe_tag;
    } stream_mark_t;

    // beat back to the edge pe
    typedef struct packed {
        logic     valid;
        logic     sos;
        logic     eos;
        pe_tag_t  pe_tag;
        fv_line_t data;
    } edge_rd_t;

    // burst sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_WRITE = 2'd1,
        SEQ_READ  = 2'd2
    } seq_state_t;

endpackage

// File: fv_req_decode.sv
module fv_req_decode
    import fv_bank_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  bank_req_t req,
    output bank_op_t  op
);

    // classified beat for this cycle
    op_kind_t  kind_d;
    op_kind_t  kind_q;
    // lines needed for a read
    line_cnt_t line_cnt_d;

    // registered beat fields, qualified by kind_q
    logic      wr_eos_q;
    node_id_t  node_id_q;
    pe_tag_t   pe_tag_q;
    line_cnt_t line_cnt_q;
    fv_line_t  data_q;

    always_comb begin
        kind_d = OP_NONE;
        if (req.valid) begin
            // rd_wr high is a write-back beat
            kind_d = req.rd_wr ? OP_WRITE_BEAT : OP_READ_START;
        end
    end

    // ceil(fv_num / FVS_PER_LINE)
    // odd counts still need the half-filled last line
    assign line_cnt_d = line_cnt_t'((int'(req.fv_num) + FVS_PER_LINE - 1) / FVS_PER_LINE);

    always_ff @(posedge clk) begin
        if (reset) begin
            kind_q <= OP_NONE;
        end else begin
            kind_q <= kind_d;
        end
    end

    // payload, only looked at when kind_q says so
    always_ff @(posedge clk) begin
        wr_eos_q   <= req.wr_eos;
        node_id_q  <= req.node_id;
        pe_tag_q   <= req.pe_tag;
        line_cnt_q <= line_cnt_d;
        data_q     <= req.data;
    end

    assign op.kind     = kind_q;
    assign op.wr_eos   = wr_eos_q;
    assign op.node_id  = node_id_q;
    assign op.pe_tag   = pe_tag_q;
    assign op.line_cnt = line_cnt_q;
    assign op.data     = data_q;

    // a read must ask for at least one and at most a full node of values
    a_read_fv_num_range: assert property (
        @(posedge clk) disable iff (reset)
        (req.valid && !req.rd_wr) |->
            (req.fv_num != '0) && (req.fv_num <= fv_count_t'(MAX_FV_NUM))
    ) else $error("read request with fv_num %0d out of range", req.fv_num);

endmodule

// File: fv_burst_seq.sv
module fv_burst_seq
    import fv_bank_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  bank_op_t     op,
    output bank_cmd_t    cmd,
    output stream_mark_t mark
);

    localparam line_idx_t FIRST_LINE = '0;

    seq_state_t state_q;
    seq_state_t state_d;
    // next line to write or read
    line_idx_t  idx_q;
    line_idx_t  idx_d;
    // node and tag held for the rest of the burst
    node_id_t   node_q;
    node_id_t   node_d;
    pe_tag_t    tag_q;
    pe_tag_t    tag_d;
    // read lines still to issue, including the current one
    line_cnt_t  remain_q;
    line_cnt_t  remain_d;

    always_comb begin
        state_d  = state_q;
        idx_d    = idx_q;
        node_d   = node_q;
        tag_d    = tag_q;
        remain_d = remain_q;
        cmd      = '0;
        mark     = '0;

        unique case (state_q)
            SEQ_IDLE: begin
                if (op.kind == OP_WRITE_BEAT) begin
                    // first write beat always lands on line 0
                    cmd.en   = 1'b1;
                    cmd.wr   = 1'b1;
                    cmd.addr = {op.node_id, FIRST_LINE};
                    cmd.data = op.data;
                    node_d   = op.node_id;
                    idx_d    = FIRST_LINE + 1'b1;
                    if (!op.wr_eos) begin
                        state_d = SEQ_WRITE;
                    end
                end else if (op.kind == OP_READ_START) begin
                    cmd.en      = 1'b1;
                    cmd.addr    = {op.node_id, FIRST_LINE};
                    mark.valid  = 1'b1;
                    mark.sos    = 1'b1;
                    mark.pe_tag = op.pe_tag;
                    // single-line read is both ends at once
                    mark.eos    = (op.line_cnt == line_cnt_t'(1));
                    node_d      = op.node_id;
                    tag_d       = op.pe_tag;
                    idx_d       = FIRST_LINE + 1'b1;
                    remain_d    = op.line_cnt - 1'b1;
                    if (op.line_cnt != line_cnt_t'(1)) begin
                        state_d = SEQ_READ;
                    end
                end
            end

            SEQ_WRITE: begin
                // gaps allowed, only write beats advance
                // reads here are dropped
                if (op.kind == OP_WRITE_BEAT) begin
                    cmd.en   = 1'b1;
                    cmd.wr   = 1'b1;
                    cmd.addr = {node_q, idx_q};
                    cmd.data = op.data;
                    idx_d    = idx_q + 1'b1;
                    if (op.wr_eos) begin
                        state_d = SEQ_IDLE;
                    end
                end
            end

            SEQ_READ: begin
                // one line per cycle, new requests ignored
                cmd.en      = 1'b1;
                cmd.addr    = {node_q, idx_q};
                mark.valid  = 1'b1;
                mark.pe_tag = tag_q;
                mark.eos    = (remain_q == line_cnt_t'(1));
                idx_d       = idx_q + 1'b1;
                remain_d    = remain_q - 1'b1;
                if (remain_q == line_cnt_t'(1)) begin
                    // back to idle, tail still in flight downstream
                    state_d = SEQ_IDLE;
                end
            end

            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= SEQ_IDLE;
            idx_q    <= '0;
            remain_q <= '0;
        end else begin
            state_q  <= state_d;
            idx_q    <= idx_d;
            remain_q <= remain_d;
        end
    end

    // held per burst, only read outside idle
    always_ff @(posedge clk) begin
        node_q <= node_d;
        tag_q  <= tag_d;
    end

    // line index wraps to 0 only after a full node of write beats
    a_write_burst_len: assert property (
        @(posedge clk) disable iff (reset)
        (state_q == SEQ_WRITE && op.kind == OP_WRITE_BEAT) |-> (idx_q != FIRST_LINE)
    ) else $error("write burst longer than %0d beats", LINES_PER_NODE);

    // a stream keeps one line per cycle until its eos
    a_stream_no_gap: assert property (
        @(posedge clk) disable iff (reset)
        (mark.valid && !mark.eos) |=> (mark.valid && !mark.sos)
    ) else $error("read stream broken before its last line");

endmodule

// File: fv_sram_bank.sv
module fv_sram_bank
    import fv_bank_pkg::*;
#(
    parameter int NUM_NODES = 64
) (
    input  logic      clk,
    input  bank_cmd_t cmd,
    output fv_line_t  rd_data
);

    // one full slot of lines per node
    localparam int DEPTH = NUM_NODES * LINES_PER_NODE;

    fv_line_t mem [DEPTH];
    // read data register, holds until the next read
    fv_line_t rd_data_q;

    always_ff @(posedge clk) begin
        if (cmd.en) begin
            if (cmd.wr) begin
                mem[cmd.addr] <= cmd.data;
            end else begin
                // one-cycle read latency
                rd_data_q <= mem[cmd.addr];
            end
        end
    end

    assign rd_data = rd_data_q;

    // sequencer must never address past the last node slot
    a_addr_in_range: assert property (
        @(posedge clk)
        cmd.en |-> (int'(cmd.addr) < DEPTH)
    ) else $error("bank address %0d beyond depth %0d", cmd.addr, DEPTH);

endmodule

// File: fv_edge_result.sv
module fv_edge_result
    import fv_bank_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  stream_mark_t mark,
    input  fv_line_t     rd_data,
    output edge_rd_t     edge_rd
);

    // mark delayed to line up with bank read data
    stream_mark_t mark_d;
    edge_rd_t     edge_rd_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            mark_d <= '0;
        end else begin
            mark_d <= mark;
        end
    end

    // mark_d and rd_data now belong to the same line
    always_ff @(posedge clk) begin
        if (reset) begin
            edge_rd_q <= '0;
        end else begin
            edge_rd_q.valid  <= mark_d.valid;
            edge_rd_q.sos    <= mark_d.valid && mark_d.sos;
            edge_rd_q.eos    <= mark_d.valid && mark_d.eos;
            edge_rd_q.pe_tag <= mark_d.pe_tag;
            // zero data on idle cycles, bank output is stale then
            edge_rd_q.data   <= mark_d.valid ? rd_data : '0;
        end
    end

    assign edge_rd = edge_rd_q;

endmodule

// File: fv_bank_ctrl.sv
module fv_bank_ctrl
    import fv_bank_pkg::*;
#(
    parameter int NUM_NODES = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  bank_req_t req,
    output edge_rd_t  edge_rd
);

    // decoded, registered request
    bank_op_t     op;
    // bank access from the sequencer
    bank_cmd_t    cmd;
    // stream markers for the read path
    stream_mark_t mark;
    // bank read data, one cycle after cmd
    fv_line_t     rd_data;

    fv_req_decode fv_req_decode_inst (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .op    (op)
    );

    fv_burst_seq fv_burst_seq_inst (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .cmd   (cmd),
        .mark  (mark)
    );

    fv_sram_bank #(
        .NUM_NODES (NUM_NODES)
    ) fv_sram_bank_inst (
        .clk     (clk),
        .cmd     (cmd),
        .rd_data (rd_data)
    );

    // registered output stage toward the edge pe
    fv_edge_result fv_edge_result_inst (
        .clk     (clk),
        .reset   (reset),
        .mark    (mark),
        .rd_data (rd_data),
        .edge_rd (edge_rd)
    );

endmodule

// File: fv_bank_vectors.svh
`ifndef FV_BANK_VECTORS_SVH
`define FV_BANK_VECTORS_SVH

// one table entry, write burst or read request
typedef struct packed {
    logic        is_write;
    // wait for every outstanding beat before this entry
    logic        drain;
    // idle cycles after the previous request beat
    logic [3:0]  gap;
    node_id_t    node;
    // write: burst length in lines, read: fv_num
    logic [4:0]  count;
    pe_tag_t     tag;
    // beats the read should produce, 0 when dropped
    logic [3:0]  exp_lines;
    // mixed into write data
    logic [15:0] seed;
} vec_t;

localparam int NUM_VECS = 14;

vec_t vecs [NUM_VECS];

// columns: is_write, drain, gap, node, count, tag, exp_lines, seed
task automatic load_vectors;
    // two full nodes, second burst right behind the first
    vecs[0]  = {1'b1, 1'b1, 4'd0, 6'd5,  5'd8,  2'd0, 4'd0, 16'h5a01};
    vecs[1]  = {1'b1, 1'b0, 4'd0, 6'd6,  5'd8,  2'd0, 4'd0, 16'h5a02};
    // full read the cycle after the last write beat
    vecs[2]  = {1'b0, 1'b0, 4'd0, 6'd5,  5'd16, 2'd1, 4'd8, 16'h0000};
    // odd counts round up
    vecs[3]  = {1'b0, 1'b1, 4'd0, 6'd6,  5'd5,  2'd2, 4'd3, 16'h0000};
    vecs[4]  = {1'b0, 1'b1, 4'd0, 6'd6,  5'd1,  2'd3, 4'd1, 16'h0000};
    // single beat burst, only line 0 changes
    vecs[5]  = {1'b1, 1'b1, 4'd0, 6'd5,  5'd1,  2'd0, 4'd0, 16'h5a03};
    vecs[6]  = {1'b0, 1'b1, 4'd0, 6'd5,  5'd16, 2'd0, 4'd8, 16'h0000};
    vecs[7]  = {1'b0, 1'b1, 4'd0, 6'd6,  5'd16, 2'd2, 4'd8, 16'h0000};
    // second read lands while the first burst runs
    vecs[8]  = {1'b0, 1'b1, 4'd0, 6'd6,  5'd16, 2'd1, 4'd8, 16'h0000};
    vecs[9]  = {1'b0, 1'b0, 4'd0, 6'd5,  5'd16, 2'd3, 4'd0, 16'h0000};
    // second request right as the first issues its last line
    vecs[10] = {1'b0, 1'b1, 4'd0, 6'd5,  5'd8,  2'd2, 4'd4, 16'h0000};
    vecs[11] = {1'b0, 1'b0, 4'd3, 6'd6,  5'd6,  2'd3, 4'd3, 16'h0000};
    // last node slot, top of the bank
    vecs[12] = {1'b1, 1'b1, 4'd0, 6'd63, 5'd8,  2'd0, 4'd0, 16'h5a04};
    vecs[13] = {1'b0, 1'b0, 4'd2, 6'd63, 5'd15, 2'd1, 4'd8, 16'h0000};
endtask

`endif

// File: tb_fv_bank_ctrl.sv
module tb_fv_bank_ctrl
    import fv_bank_pkg::*;
;

    localparam int DRAIN_TIMEOUT = 40;

    // one expected beat on edge_rd
    typedef struct packed {
        logic [31:0] cycle;
        logic        sos;
        logic        eos;
        pe_tag_t     tag;
        fv_line_t    data;
    } beat_t;

    logic      clk;
    logic      reset;
    bank_req_t req;
    edge_rd_t  edge_rd;

    // written contents, indexed like bank_addr_t
    fv_line_t    shadow [1 << BANK_ADDR_WIDTH];
    beat_t       exp_q [$];
    int unsigned cyc = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          beats_seen = 0;
    int          expected_beats = 0;
    bit          timed_out = 1'b0;

    `include "fv_bank_vectors.svh"

    fv_bank_ctrl #(
        .NUM_NODES (64)
    ) fv_bank_ctrl_inst (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .edge_rd (edge_rd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc++;

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic compare_field(input string name, input logic [63:0] want,
                                 input logic [63:0] got);
        assert (got === want) else begin
            value_errors++;
            $display("error at %0t: %s expected %0h got %0h", $time, name, want, got);
        end
    endtask

    // one beat per cycle, line index counts up from 0
    task automatic issue_write(input vec_t v);
        bank_addr_t addr;
        int         i;
        for (i = 0; i < v.count; i++) begin
            addr = {v.node, line_idx_t'(i)};
            // address in the low bits keeps every line distinct
            shadow[addr] = {$urandom(), v.seed, 7'd0, addr};
            req         = '0;
            req.valid   = 1'b1;
            req.rd_wr   = 1'b1;
            req.wr_eos  = (i == v.count - 1);
            req.node_id = v.node;
            req.data    = shadow[addr];
            next_cycle();
        end
        req = '0;
    endtask

    task automatic issue_read(input vec_t v);
        beat_t b;
        int    k;
        req         = '0;
        req.valid   = 1'b1;
        req.node_id = v.node;
        req.pe_tag  = v.tag;
        req.fv_num  = v.count;
        // line k shows up three cycles after the request, plus k
        for (k = 0; k < v.exp_lines; k++) begin
            b.cycle = cyc + 3 + k;
            b.sos   = (k == 0);
            b.eos   = (k == v.exp_lines - 1);
            b.tag   = v.tag;
            b.data  = shadow[{v.node, line_idx_t'(k)}];
            exp_q.push_back(b);
        end
        expected_beats += v.exp_lines;
        next_cycle();
        req = '0;
    endtask

    task automatic wait_for_drain;
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            next_cycle();
            n++;
        end
        assert (exp_q.size() == 0) else begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout: %0d read beats never arrived on edge_rd", exp_q.size());
        end
    endtask

    // edge_rd is stable at the falling edge
    always @(negedge clk) begin : check_beats
        beat_t want;
        if (edge_rd.valid === 1'b1) begin
            beats_seen++;
            assert (exp_q.size() != 0) else begin
                other_errors++;
                $display("beat on edge_rd at %0t with no read outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                compare_field("edge_rd arrival cycle", want.cycle, cyc);
                compare_field("edge_rd.sos", want.sos, edge_rd.sos);
                compare_field("edge_rd.eos", want.eos, edge_rd.eos);
                compare_field("edge_rd.pe_tag", want.tag, edge_rd.pe_tag);
                compare_field("edge_rd.data", want.data, edge_rd.data);
            end
        end else begin
            // idle output, also covers the reset window
            compare_field("edge_rd.valid", 1'b0, edge_rd.valid);
            compare_field("edge_rd.sos", 1'b0, edge_rd.sos);
            compare_field("edge_rd.eos", 1'b0, edge_rd.eos);
            // data held at zero between beats
            compare_field("edge_rd.data", 64'd0, edge_rd.data);
        end
    end

    initial begin : run_table
        int unsigned seed_draw;
        int          i;
        req       = '0;
        reset     = 1'b1;
        seed_draw = $urandom(32'h9dc9);
        load_vectors();
        repeat (16) next_cycle();
        reset = 1'b0;
        repeat (2) next_cycle();
        for (i = 0; i < NUM_VECS; i++) begin
            if (vecs[i].drain && !timed_out) begin
                wait_for_drain();
            end
            if (!timed_out) begin
                repeat (vecs[i].gap) next_cycle();
                if (vecs[i].is_write) begin
                    issue_write(vecs[i]);
                end else begin
                    issue_read(vecs[i]);
                end
            end
        end
        if (!timed_out) begin
            wait_for_drain();
        end
        // stray beats from a dropped request would land here
        repeat (12) next_cycle();
        assert (beats_seen == expected_beats) else begin
            other_errors++;
            $display("saw %0d beats on edge_rd, table expects %0d", beats_seen,
                     expected_beats);
        end
        $display("value errors %0d, other errors %0d, beats %0d of %0d",
                 value_errors, other_errors, beats_seen, expected_beats);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
fv_bank_pkg.sv
fv_req_decode.sv
fv_burst_seq.sv
fv_sram_bank.sv
fv_edge_result.sv
fv_bank_ctrl.sv
tb_fv_bank_ctrl.sv

// File: Bender.yml
package:
  name: fv_bank_ctrl

sources:
  - files:
      - fv_bank_pkg.sv
      - fv_req_decode.sv
      - fv_burst_seq.sv
      - fv_sram_bank.sv
      - fv_edge_result.sv
      - fv_bank_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fv_bank_ctrl.sv
